// ==== common/mc_cfg.svh ====
`ifndef MC_CFG_SVH
`define MC_CFG_SVH

// tile coordinate widths
`define MC_X_CORD_WIDTH 4
`define MC_Y_CORD_WIDTH 4

// remote store payload
`define MC_DATA_WIDTH 32
`define MC_ADDR_WIDTH 16

// entries in each endpoint FIFO
`define MC_FIFO_ELS 4

// outbound credits, also the reset value of the counter
`define MC_MAX_OUT_CREDITS 8

// tile comes out of reset frozen
`define MC_FREEZE_INIT 1'b1

`endif

// ==== common/mc_pkg.sv ====
`include "mc_cfg.svh"

package mc_pkg;

   // opcode carried in every forward packet
   typedef enum logic [1:0]
   {
      MC_OP_STORE    = 2'b00,
      MC_OP_FREEZE   = 2'b01,
      MC_OP_UNFREEZE = 2'b10,
      MC_OP_UNKNOWN  = 2'b11
   } mc_op_e;

   // forward channel packet, remote store or freeze command
   typedef struct packed
   {
      mc_op_e                           op;
      logic [(`MC_DATA_WIDTH>>3)-1:0]   mask;
      logic [`MC_ADDR_WIDTH-1:0]        addr;
      logic [`MC_DATA_WIDTH-1:0]        data;
      logic [`MC_X_CORD_WIDTH-1:0]      src_x;
      logic [`MC_Y_CORD_WIDTH-1:0]      src_y;
      logic [`MC_X_CORD_WIDTH-1:0]      dst_x;
      logic [`MC_Y_CORD_WIDTH-1:0]      dst_y;
   } mc_packet_s;

   // reverse channel carries only the credit destination
   typedef struct packed
   {
      logic [`MC_X_CORD_WIDTH-1:0]      dst_x;
      logic [`MC_Y_CORD_WIDTH-1:0]      dst_y;
   } mc_return_packet_s;

   // one direction of a mesh link
   // the ready bits flow against the data of the other direction
   typedef struct packed
   {
      logic                             fwd_v;
      mc_packet_s                       fwd_data;
      logic                             fwd_ready;
      logic                             rev_v;
      mc_return_packet_s                rev_data;
      logic                             rev_ready;
   } mc_link_s;

endpackage

// ==== rtl/mc_fifo.sv ====
`timescale 1ns/10ps

module mc_fifo
   #(parameter int  els_p     = 4
   , parameter type payload_t = logic
   )
   (input  logic     clk_i
   , input  logic     reset_i

   // enqueue side, valid/ready
   , input  logic     v_i
   , input  payload_t data_i
   , output logic     ready_o

   // dequeue side, valid/yumi
   , output logic     v_o
   , output payload_t data_o
   , input  logic     yumi_i
   );

   localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
   localparam int cnt_width_lp = $clog2(els_p + 1);

   payload_t                 mem_r [els_p];
   logic [ptr_width_lp-1:0]  rd_ptr_r;
   logic [ptr_width_lp-1:0]  wr_ptr_r;
   logic [cnt_width_lp-1:0]  count_r;
   logic                     enq;
   logic                     deq;

   assign ready_o = (count_r != cnt_width_lp'(els_p));
   assign v_o     = (count_r != '0);
   assign data_o  = mem_r[rd_ptr_r];

   assign enq = v_i & ready_o;
   assign deq = yumi_i & v_o;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rd_ptr_r <= '0;
         wr_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (enq)
            wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
         if (deq)
            rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
         // simultaneous enq and deq leave the count alone
         if (enq & ~deq)
            count_r <= count_r + 1'b1;
         else if (deq & ~enq)
            count_r <= count_r - 1'b1;
      end
   end

   // storage
   always_ff @(posedge clk_i)
   begin
      if (enq)
         mem_r[wr_ptr_r] <= data_i;
   end

endmodule

// ==== endpoint/mc_pkt_decode.sv ====
`timescale 1ns/10ps
`include "mc_cfg.svh"

module mc_pkt_decode
   import mc_pkg::*;
   (input  logic                           v_i
   , input  mc_packet_s                     data_i

   , output logic                           pkt_freeze_o
   , output logic                           pkt_unfreeze_o
   , output logic                           pkt_unknown_o
   , output logic                           pkt_store_o

   // store fields for the tile
   , output logic [`MC_DATA_WIDTH-1:0]      data_o
   , output logic [`MC_ADDR_WIDTH-1:0]      addr_o
   , output logic [(`MC_DATA_WIDTH>>3)-1:0] mask_o
   );

   // only a valid head counts
   assign pkt_store_o    = v_i & (data_i.op == MC_OP_STORE);
   assign pkt_freeze_o   = v_i & (data_i.op == MC_OP_FREEZE);
   assign pkt_unfreeze_o = v_i & (data_i.op == MC_OP_UNFREEZE);
   assign pkt_unknown_o  = v_i & (data_i.op == MC_OP_UNKNOWN);

   assign data_o = data_i.data;
   assign addr_o = data_i.addr;
   assign mask_o = data_i.mask;

endmodule

// ==== endpoint/mc_credit_counter.sv ====
`timescale 1ns/10ps

module mc_credit_counter
   #(parameter int max_val_p = 8
   )
   (input  logic                             clk_i
   , input  logic                             reset_i
   , input  logic                             up_i
   , input  logic                             down_i
   , output logic [$clog2(max_val_p+1)-1:0]   count_o
   );

   localparam int width_lp = $clog2(max_val_p + 1);

   logic [width_lp-1:0] count_r;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         count_r <= width_lp'(max_val_p);
      // an up and a down together cancel out
      else if (up_i & ~down_i & (count_r != width_lp'(max_val_p)))
         count_r <= count_r + 1'b1;
      else if (down_i & ~up_i & (count_r != '0))
         count_r <= count_r - 1'b1;
   end

   assign count_o = count_r;

endmodule

// ==== endpoint/mc_endpoint.sv ====
`timescale 1ns/10ps
`include "mc_cfg.svh"

module mc_endpoint
   import mc_pkg::*;
   (input  logic       clk_i
   , input  logic       reset_i

   // mesh link pair
   , input  mc_link_s   link_i
   , output mc_link_s   link_o

   // head of the request FIFO
   , output logic       fifo_v_o
   , output mc_packet_s fifo_data_o
   , input  logic       fifo_yumi_i

   // store consumed by the tile, triggers a credit return
   , input  logic       store_yumi_i

   // outbound stores from the tile
   , input  logic       out_v_i
   , input  mc_packet_s out_packet_i
   , output logic       out_ready_o

   , output logic       credit_v_o
   );

   logic              req_ready;
   logic              req_v;
   mc_packet_s        req_data;
   logic              ret_ready;
   logic              ret_v;
   mc_return_packet_s ret_in;
   mc_return_packet_s ret_data;
   logic              ret_yumi;
   logic              credit_v_r;

   // incoming remote stores and freeze commands
   mc_fifo #(.els_p(`MC_FIFO_ELS), .payload_t(mc_packet_s)) req_fifo
      (.clk_i   (clk_i)
      ,.reset_i (reset_i)
      ,.v_i     (link_i.fwd_v)
      ,.data_i  (link_i.fwd_data)
      ,.ready_o (req_ready)
      ,.v_o     (req_v)
      ,.data_o  (req_data)
      ,.yumi_i  (fifo_yumi_i)
      );

   // credit goes back to whoever sent the store
   assign ret_in.dst_x = req_data.src_x;
   assign ret_in.dst_y = req_data.src_y;

   mc_fifo #(.els_p(`MC_FIFO_ELS), .payload_t(mc_return_packet_s)) ret_fifo
      (.clk_i   (clk_i)
      ,.reset_i (reset_i)
      ,.v_i     (store_yumi_i)
      ,.data_i  (ret_in)
      ,.ready_o (ret_ready)
      ,.v_o     (ret_v)
      ,.data_o  (ret_data)
      ,.yumi_i  (ret_yumi)
      );

   assign ret_yumi = ret_v & link_i.rev_ready;

   // hold off the head while a return could not be queued
   assign fifo_v_o    = req_v & ret_ready;
   assign fifo_data_o = req_data;

   // outbound path is a pure pass-through
   assign link_o.fwd_v     = out_v_i;
   assign link_o.fwd_data  = out_packet_i;
   assign out_ready_o      = link_i.fwd_ready;

   assign link_o.fwd_ready = req_ready;
   assign link_o.rev_v     = ret_v;
   assign link_o.rev_data  = ret_data;
   // credits are never refused
   assign link_o.rev_ready = 1'b1;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         credit_v_r <= 1'b0;
      else
         credit_v_r <= link_i.rev_v;
   end

   assign credit_v_o = credit_v_r;

endmodule

// ==== endpoint/mc_endpoint_standard.sv ====
`timescale 1ns/10ps
`include "mc_cfg.svh"

module mc_endpoint_standard
   import mc_pkg::*;
   (input  logic                                     clk_i
   , input  logic                                     reset_i

   , input  mc_link_s                                 link_i
   , output mc_link_s                                 link_o

   // incoming stores to the tile
   , output logic                                     in_v_o
   , input  logic                                     in_yumi_i
   , output logic [`MC_DATA_WIDTH-1:0]                in_data_o
   , output logic [(`MC_DATA_WIDTH>>3)-1:0]           in_mask_o
   , output logic [`MC_ADDR_WIDTH-1:0]                in_addr_o

   // outgoing stores from the tile
   , input  logic                                     out_v_i
   , input  mc_packet_s                               out_packet_i
   , output logic                                     out_ready_o

   , output logic [$clog2(`MC_MAX_OUT_CREDITS+1)-1:0] out_credits_o
   , output logic                                     freeze_r_o
   );

   logic       fifo_v;
   mc_packet_s fifo_data;
   logic       fifo_yumi;
   logic       credit_v;
   logic       pkt_freeze;
   logic       pkt_unfreeze;
   // unknown opcodes are left sitting at the head
   logic       pkt_unknown;
   logic       freeze_r;

   mc_endpoint endpoint
      (.clk_i        (clk_i)
      ,.reset_i      (reset_i)
      ,.link_i       (link_i)
      ,.link_o       (link_o)
      ,.fifo_v_o     (fifo_v)
      ,.fifo_data_o  (fifo_data)
      ,.fifo_yumi_i  (fifo_yumi)
      ,.store_yumi_i (in_yumi_i)
      ,.out_v_i      (out_v_i)
      ,.out_packet_i (out_packet_i)
      ,.out_ready_o  (out_ready_o)
      ,.credit_v_o   (credit_v)
      );

   // freeze commands are consumed here, stores by the tile
   assign fifo_yumi = in_yumi_i | pkt_freeze | pkt_unfreeze;

   mc_pkt_decode decode
      (.v_i            (fifo_v)
      ,.data_i         (fifo_data)
      ,.pkt_freeze_o   (pkt_freeze)
      ,.pkt_unfreeze_o (pkt_unfreeze)
      ,.pkt_unknown_o  (pkt_unknown)
      ,.pkt_store_o    (in_v_o)
      ,.data_o         (in_data_o)
      ,.addr_o         (in_addr_o)
      ,.mask_o         (in_mask_o)
      );

   mc_credit_counter #(.max_val_p(`MC_MAX_OUT_CREDITS)) out_credits
      (.clk_i   (clk_i)
      ,.reset_i (reset_i)
      ,.up_i    (credit_v)
      ,.down_i  (out_v_i & out_ready_o)
      ,.count_o (out_credits_o)
      );

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         freeze_r <= `MC_FREEZE_INIT;
      else if (pkt_freeze | pkt_unfreeze)
         freeze_r <= pkt_freeze;
   end

   assign freeze_r_o = freeze_r;

endmodule

// ==== tests/endpoint_sva.sv ====
`timescale 1ns/10ps

module endpoint_sva
   import mc_pkg::*;
   (input  logic     clk_i
   , input  logic     reset_i
   , input  logic     unknown_i
   , input  logic     in_v_i
   , input  logic     in_yumi_i
   , input  mc_link_s link_i
   , input  mc_link_s link_o
   );

   // number of failed assertions
   int fail_cnt = 0;

   // an unknown opcode would block the head for good
   no_unknown_head: assert property (@(posedge clk_i) disable iff (reset_i)
      !unknown_i)
      else
      begin
         fail_cnt++;
         $error("unknown opcode valid at the head of the request FIFO");
      end

   yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      in_yumi_i |-> in_v_i)
      else
      begin
         fail_cnt++;
         $error("in_yumi_i high while in_v_o is low");
      end

   // return held until the mesh takes it
   rev_held: assert property (@(posedge clk_i) disable iff (reset_i)
      (link_o.rev_v && !link_i.rev_ready) |=> (link_o.rev_v && $stable(link_o.rev_data)))
      else
      begin
         fail_cnt++;
         $error("return packet changed or dropped while rev_ready was low");
      end

endmodule

bind mc_endpoint_standard endpoint_sva sva
   (.clk_i     (clk_i)
   ,.reset_i   (reset_i)
   ,.unknown_i (pkt_unknown)
   ,.in_v_i    (in_v_o)
   ,.in_yumi_i (in_yumi_i)
   ,.link_i    (link_i)
   ,.link_o    (link_o)
   );

// ==== tests/endpoint_checker.sv ====
`timescale 1ns/10ps
`include "mc_cfg.svh"

module endpoint_checker
   import mc_pkg::*;
   (input  logic                                     clk_i
   , input  logic                                     reset_i
   , input  mc_link_s                                 link_i
   , input  mc_link_s                                 link_o
   , input  logic                                     in_v_i
   , input  logic                                     in_yumi_i
   , input  logic [`MC_DATA_WIDTH-1:0]                in_data_i
   , input  logic [(`MC_DATA_WIDTH>>3)-1:0]           in_mask_i
   , input  logic [`MC_ADDR_WIDTH-1:0]                in_addr_i
   , input  logic                                     out_v_i
   , input  mc_packet_s                               out_packet_i
   , input  logic                                     out_ready_i
   , input  logic [$clog2(`MC_MAX_OUT_CREDITS+1)-1:0] out_credits_i
   , input  logic                                     freeze_r_i
   , output int                                       store_err_o
   , output int                                       freeze_err_o
   , output int                                       return_err_o
   , output int                                       credit_err_o
   , output int                                       out_err_o
   , output logic                                     drained_o
   );

   localparam int max_cred_lp = `MC_MAX_OUT_CREDITS;

   mc_packet_s        req_q[$];
   mc_return_packet_s ret_q[$];
   logic              freeze_m;
   int                cred_m;
   logic              credit_d1;

   task automatic mismatch(input string msg);
      $display("FAIL %0t: %s", $time, msg);
   endtask

   // all DUT outputs are sampled at the rising edge, before they update
   always @(posedge clk_i)
   begin
      int                req_cnt;
      int                ret_cnt;
      logic              head_v;
      logic              exp_in_v;
      logic              launch;
      mc_packet_s        head;
      mc_return_packet_s ret;
      if (reset_i)
      begin
         req_q.delete();
         ret_q.delete();
         freeze_m     = `MC_FREEZE_INIT;
         cred_m       = max_cred_lp;
         credit_d1    = 1'b0;
         store_err_o  = 0;
         freeze_err_o = 0;
         return_err_o = 0;
         credit_err_o = 0;
         out_err_o    = 0;
      end
      else
      begin
         req_cnt  = req_q.size();
         ret_cnt  = ret_q.size();
         // head is held back while the return FIFO is full
         head_v   = (req_cnt > 0) && (ret_cnt < `MC_FIFO_ELS);
         head     = (req_cnt > 0) ? req_q[0] : '0;
         exp_in_v = head_v && (head.op == MC_OP_STORE);
         launch   = out_v_i && out_ready_i;

         if (freeze_r_i !== freeze_m)
         begin
            freeze_err_o++;
            mismatch($sformatf("freeze_r_o is %b, expected %b", freeze_r_i, freeze_m));
         end
         if (in_v_i !== exp_in_v)
         begin
            store_err_o++;
            mismatch($sformatf("in_v_o is %b, expected %b", in_v_i, exp_in_v));
         end
         else if (exp_in_v && ((in_data_i !== head.data) || (in_addr_i !== head.addr)
            || (in_mask_i !== head.mask)))
         begin
            store_err_o++;
            mismatch($sformatf("store %h/%h/%h, expected %h/%h/%h", in_data_i, in_addr_i,
               in_mask_i, head.data, head.addr, head.mask));
         end
         if (link_o.fwd_ready !== (req_cnt < `MC_FIFO_ELS))
         begin
            store_err_o++;
            mismatch($sformatf("link_o.fwd_ready is %b with %0d queued", link_o.fwd_ready,
               req_cnt));
         end

         // credit returns, in store order
         if (link_o.rev_v !== (ret_cnt > 0))
         begin
            return_err_o++;
            mismatch($sformatf("link_o.rev_v is %b with %0d returns due", link_o.rev_v,
               ret_cnt));
         end
         else if (ret_cnt > 0)
         begin
            if (link_o.rev_data !== ret_q[0])
            begin
               return_err_o++;
               mismatch($sformatf("return to %h, expected %h", link_o.rev_data, ret_q[0]));
            end
            if (link_i.rev_ready)
               ret = ret_q.pop_front();
         end

         if (head_v && (head.op != MC_OP_STORE))
         begin
            freeze_m = (head.op == MC_OP_FREEZE);
            head     = req_q.pop_front();
         end
         else if (exp_in_v && in_yumi_i)
         begin
            ret.dst_x = head.src_x;
            ret.dst_y = head.src_y;
            ret_q.push_back(ret);
            head = req_q.pop_front();
         end
         if (link_i.fwd_v && link_o.fwd_ready)
            req_q.push_back(link_i.fwd_data);

         if ((link_o.fwd_v !== out_v_i) || (out_ready_i !== link_i.fwd_ready)
            || (out_v_i && (link_o.fwd_data !== out_packet_i)))
         begin
            out_err_o++;
            mismatch("outbound link differs from the tile's packet or ready");
         end

         // credits are always accepted from the mesh
         if (link_o.rev_ready !== 1'b1)
         begin
            credit_err_o++;
            mismatch("link_o.rev_ready is not high, a credit return would be refused");
         end
         if ((int'(out_credits_i) != cred_m) || (int'(out_credits_i) > max_cred_lp))
         begin
            credit_err_o++;
            mismatch($sformatf("out_credits_o is %0d, expected %0d", out_credits_i, cred_m));
         end
         // a credit counts two edges after it arrives, a launch on the next edge
         if (credit_d1 && !launch && (cred_m < max_cred_lp))
            cred_m++;
         else if (!credit_d1 && launch && (cred_m > 0))
            cred_m--;
         credit_d1 = link_i.rev_v && link_o.rev_ready;
      end
      drained_o <= (req_q.size() == 0) && (ret_q.size() == 0);
   end

endmodule

// ==== tests/tb_endpoint.sv ====
`timescale 1ns/10ps
`include "mc_cfg.svh"

module tb_endpoint
   import mc_pkg::*;
   ();

   localparam int num_pkts_lp = 300;
   localparam int period_lp   = 100;
   localparam int cred_w_lp   = $clog2(`MC_MAX_OUT_CREDITS + 1);

   logic                           clk_i;
   logic                           reset_i;
   mc_link_s                       link_i;
   mc_link_s                       link_o;
   logic                           in_v_o;
   logic                           in_yumi_i;
   logic [`MC_DATA_WIDTH-1:0]      in_data_o;
   logic [(`MC_DATA_WIDTH>>3)-1:0] in_mask_o;
   logic [`MC_ADDR_WIDTH-1:0]      in_addr_o;
   logic                           out_v_i;
   mc_packet_s                     out_packet_i;
   logic                           out_ready_o;
   logic [cred_w_lp-1:0]           out_credits_o;
   logic                           freeze_r_o;
   int                             store_errs;
   int                             freeze_errs;
   int                             return_errs;
   int                             credit_errs;
   int                             out_errs;
   logic                           drained;
   logic [31:0]                    rng;

   mc_endpoint_standard UUT (.*);

   endpoint_checker chk
      (.clk_i         (clk_i)
      ,.reset_i       (reset_i)
      ,.link_i        (link_i)
      ,.link_o        (link_o)
      ,.in_v_i        (in_v_o)
      ,.in_yumi_i     (in_yumi_i)
      ,.in_data_i     (in_data_o)
      ,.in_mask_i     (in_mask_o)
      ,.in_addr_i     (in_addr_o)
      ,.out_v_i       (out_v_i)
      ,.out_packet_i  (out_packet_i)
      ,.out_ready_i   (out_ready_o)
      ,.out_credits_i (out_credits_o)
      ,.freeze_r_i    (freeze_r_o)
      ,.store_err_o   (store_errs)
      ,.freeze_err_o  (freeze_errs)
      ,.return_err_o  (return_errs)
      ,.credit_err_o  (credit_errs)
      ,.out_err_o     (out_errs)
      ,.drained_o     (drained)
      );

   always #(period_lp / 2) clk_i = ~clk_i;

   function automatic logic [31:0] xorshift32();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic mc_packet_s rand_packet(input logic cmd_ok);
      mc_packet_s  p;
      logic [31:0] r;
      r = xorshift32();
      p.op = MC_OP_STORE;
      // about one in ten becomes a freeze or unfreeze command
      if (cmd_ok && (r % 32'd10 == 32'd0))
         p.op = r[3] ? MC_OP_FREEZE : MC_OP_UNFREEZE;
      p.addr  = r[31:16];
      p.mask  = r[15:12];
      p.src_x = r[11:8];
      p.src_y = r[7:4];
      p.dst_x = 4'h3;
      p.dst_y = 4'h5;
      p.data  = xorshift32();
      return p;
   endfunction

   initial
   begin
      int          sent;
      int          offered;
      int          owed;
      int          errs;
      logic        fwd_taken;
      logic        launched;
      logic        done;
      logic [31:0] r;
      clk_i        = 1'b0;
      reset_i      = 1'b1;
      rng          = 32'd82428;
      link_i       = '0;
      in_yumi_i    = 1'b0;
      out_v_i      = 1'b0;
      out_packet_i = '0;
      sent         = 0;
      offered      = 0;
      owed         = 0;
      done         = 1'b0;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;
      while (!done)
      begin
         @(posedge clk_i);
         // drained holds the state left by the previous edge, so judge completion first
         done = (sent == num_pkts_lp) && drained && (owed == 0) && !out_v_i
            && (out_credits_o == cred_w_lp'(`MC_MAX_OUT_CREDITS));
         fwd_taken = link_i.fwd_v & link_o.fwd_ready;
         launched  = out_v_i & out_ready_o;
         if (fwd_taken)
            sent++;
         if (launched)
            owed++;
         @(negedge clk_i);
         r = xorshift32();
         // mesh side, a packet is held until it is taken
         if (!link_i.fwd_v || fwd_taken)
         begin
            link_i.fwd_v = 1'b0;
            if ((offered < num_pkts_lp) && (r[1:0] != 2'b00))
            begin
               link_i.fwd_data = rand_packet(1'b1);
               link_i.fwd_v    = 1'b1;
               offered++;
            end
         end
         link_i.fwd_ready = (r[3:2] != 2'b00);
         link_i.rev_ready = r[4];
         // credit returns after a random delay
         link_i.rev_v = 1'b0;
         if ((owed > 0) && (r[7:6] == 2'b00))
         begin
            link_i.rev_v    = 1'b1;
            link_i.rev_data = r[23:16];
            owed--;
         end
         // tile side
         in_yumi_i = in_v_o & r[5];
         if (!out_v_i || launched)
         begin
            out_v_i = 1'b0;
            if ((offered < num_pkts_lp) && (out_credits_o != '0) && r[8])
            begin
               out_packet_i = rand_packet(1'b0);
               out_v_i      = 1'b1;
            end
         end
      end
      errs = store_errs + freeze_errs + return_errs + credit_errs + out_errs
         + UUT.sva.fail_cnt;
      $display("errors: store %0d, freeze %0d, return %0d, credit %0d, outbound %0d, %s %0d",
         store_errs, freeze_errs, return_errs, credit_errs, out_errs, "assertion",
         UUT.sva.fail_cnt);
      if (errs == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   // watchdog, 20 cycles per packet
   initial
   begin
      #(20 * num_pkts_lp * period_lp);
      $display("timeout: packets or credits were still outstanding when time ran out");
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+common
common/mc_pkg.sv
rtl/mc_fifo.sv
endpoint/mc_pkt_decode.sv
endpoint/mc_credit_counter.sv
endpoint/mc_endpoint.sv
endpoint/mc_endpoint_standard.sv
tests/endpoint_sva.sv
tests/endpoint_checker.sv
tests/tb_endpoint.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_endpoint

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_endpoint -f vlog.f

run: compile
	./$(SIM) | tee run.log
	grep -q "Simulation PASSED" run.log

clean:
	rm -rf obj_dir run.log
